// ==== all.f ====
+incdir+dv
logic/key_extract_pkg.sv
logic/key_ifs.sv
logic/key_cfg_ctrl.sv
logic/tenant_table.sv
logic/field_select.sv
logic/predicate_unit.sv
logic/key_assemble.sv
logic/key_extract_top.sv
dv/key_extract_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = key_extract_tb
RTL_TOP  = key_extract_top
FILELIST = all.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== dv/key_extract_tests.svh ====
/*
 * Directed tests of the key extractor testbench.
 * Every test returns with cfg_req and phv_valid_in low.
 */
`ifndef KEY_EXTRACT_TESTS_SVH
`define KEY_EXTRACT_TESTS_SVH

// one four-phase request, model updated once it completes
task automatic cfg_write(input cfg_sel_e sel, input tenant_t idx, input key_t data);
    int n;
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_sel   <= sel;
    cfg_index <= idx;
    cfg_data  <= data;
    @(negedge clk);
    if (cfg_ack !== 1'b0) report_error("cfg_ack was high before cfg_req was sampled");
    n = 0;
    while (cfg_ack !== 1'b1 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (cfg_ack !== 1'b1) report_error("timeout waiting for cfg_ack to rise");
    // ack stays up while req is held
    repeat (2) begin
        @(negedge clk);
        if (cfg_ack !== 1'b1) value_mismatch("cfg_ack", phv_t'(cfg_ack), phv_t'(1'b1));
    end
    @(posedge clk);
    cfg_req <= 1'b0;
    @(negedge clk);
    if (cfg_ack !== 1'b1) report_error("cfg_ack fell in the same cycle as cfg_req");
    n = 0;
    while (cfg_ack !== 1'b0 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (cfg_ack !== 1'b0) report_error("timeout waiting for cfg_ack to fall");
    if (sel == SEL_OFFSET) begin
        off_model[idx] = data[8:0];
    end else begin
        mask_model[idx] = data;
    end
endtask

task automatic write_tenant(input tenant_t ten, input key_off_t off);
    logic [127:0] r;
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    // bits above the entry are random, the offset table keeps the low 9
    cfg_write(SEL_OFFSET, ten, {r[100:9], off});
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    cfg_write(SEL_MASK, ten, r[100:0]);
endtask

task automatic test_reset_state();
    n_tests++;
    @(negedge clk);
    if (cfg_ack !== 1'b0) value_mismatch("cfg_ack", phv_t'(cfg_ack), '0);
    if (phv_valid_out !== 1'b0) value_mismatch("phv_valid_out", phv_t'(phv_valid_out), '0);
    if (key_valid_out !== 1'b0) value_mismatch("key_valid_out", phv_t'(key_valid_out), '0);
    if (key_out !== '0) value_mismatch("key_out", phv_t'(key_out), '0);
    if (phv_out !== '0) value_mismatch("phv_out", phv_out, '0);
endtask

task automatic test_cfg_handshake();
    key_off_t off;
    n_tests++;
    off = {3'd5, 3'd2, 3'd6};
    write_tenant(4'd3, off);
    fill_conts();
    build_phv(4'd3, 20'($random(seed)), phv_seq[0]);
    vld_seq[0] = 1'b1;
    run_stream(1);
endtask

// two tenants back to back, each must see its own entries
task automatic test_tenant_isolation();
    n_tests++;
    write_tenant(4'd9, {3'd1, 3'd7, 3'd0});
    write_tenant(4'd12, {3'd6, 3'd0, 3'd3});
    for (int i = 0; i < 8; i++) begin
        fill_conts();
        build_phv((i % 2 == 0) ? 4'd9 : 4'd12, 20'($random(seed)), phv_seq[i]);
        vld_seq[i] = 1'b1;
    end
    run_stream(8);
endtask

// valid case at 2k, idle copy at 2k+1
task automatic pred_case(input int k, input logic [1:0] cmp, input logic ia,
                         input logic [7:0] fa, input logic ib, input logic [7:0] fb,
                         input logic exp);
    build_phv(4'd0, {cmp, ia, fa, ib, fb}, phv_seq[2 * k]);
    vld_seq[2 * k]      = 1'b1;
    pred_seq[2 * k]     = exp;
    phv_seq[2 * k + 1]  = phv_seq[2 * k];
    vld_seq[2 * k + 1]  = 1'b0;
endtask

task automatic test_predicate();
    n_tests++;
    fill_conts();
    // operand bytes 6B[2] = 4B[5] = 0x40, 2B[1] = 0x10
    cont6[2][7:0] = 8'h40;
    cont4[5][7:0] = 8'h40;
    cont2[1][7:0] = 8'h10;
    pred_case(0, 2'b00, 1'b1, 8'h05, 1'b1, 8'h03, 1'b1);
    pred_case(1, 2'b00, 1'b1, 8'h03, 1'b1, 8'h03, 1'b0);
    pred_case(2, 2'b01, 1'b1, 8'h03, 1'b1, 8'h03, 1'b1);
    pred_case(3, 2'b01, 1'b0, 8'h12, 1'b1, 8'h41, 1'b0);
    pred_case(4, 2'b10, 1'b0, 8'h12, 1'b0, 8'h0d, 1'b1);
    pred_case(5, 2'b10, 1'b0, 8'h01, 1'b0, 8'h0d, 1'b0);
    pred_case(6, 2'b00, 1'b0, 8'h0d, 1'b0, 8'h01, 1'b1);
    // type 11 reads the 2-byte container
    pred_case(7, 2'b10, 1'b0, 8'h19, 1'b1, 8'h10, 1'b1);
    pred_case(8, 2'b11, 1'b1, 8'h00, 1'b1, 8'hff, 1'b1);
    pred_case(9, 2'b01, 1'b1, 8'h10, 1'b0, 8'h01, 1'b1);
    pred_chk = 1'b1;
    run_stream(20);
    pred_chk = 1'b0;
endtask

task automatic test_streaming();
    logic [31:0] r;
    tenant_t     ten;
    n_tests++;
    for (int i = 0; i < 28; i++) begin
        r = $random(seed);
        case (r[1:0])
            2'd0:    ten = 4'd3;
            2'd1:    ten = 4'd9;
            2'd2:    ten = 4'd12;
            default: ten = 4'd6;
        endcase
        fill_conts();
        build_phv(ten, r[31:12], phv_seq[i]);
        vld_seq[i] = (r[3:2] != 2'b00);
    end
    run_stream(28);
endtask

`endif

// ==== dv/key_extract_tb.sv ====
/*
 * Testbench for the key extractor, built with STAGE_ID 0.
 * off_model and mask_model mirror the DUT tables and are updated by
 * cfg_write. Expected keys are taken from the PHV layout of the stage.
 * Outputs are sampled on the falling clock edge.
 */
`timescale 1ns/1ps

module key_extract_tb;
    import key_extract_pkg::*;

    localparam int STAGE   = 0;
    localparam int TIMEOUT = 20;
    // lsb of container 0 in each region, top bit of opcode 0, tenant ID lsb
    localparam int C6_LSB  = 740;
    localparam int C4_LSB  = 484;
    localparam int C2_LSB  = 356;
    localparam int OP0_TOP = 355;
    localparam int TEN_LSB = 133;

    logic     clk;
    logic     rst_n;
    phv_t     phv_in;
    logic     phv_valid_in;
    logic     cfg_req;
    cfg_sel_e cfg_sel;
    tenant_t  cfg_index;
    key_t     cfg_data;
    logic     cfg_ack;
    phv_t     phv_out;
    logic     phv_valid_out;
    key_t     key_out;
    logic     key_valid_out;
    key_t     key_mask_out;

    integer seed     = 90;
    int     n_errors = 0;
    int     n_tests  = 0;

    // containers packed by the next build_phv
    logic [47:0] cont6 [8];
    logic [31:0] cont4 [8];
    logic [15:0] cont2 [8];

    key_off_t off_model  [16];
    key_t     mask_model [16];

    // one entry per input cycle of run_stream
    phv_t phv_seq  [32];
    logic vld_seq  [32];
    logic pred_seq [32];
    logic pred_chk;

    key_extract_top #(.STAGE_ID(STAGE)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic value_mismatch(input string name, input phv_t got, input phv_t exp);
        $display("FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        n_errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        n_errors++;
    endtask

    task automatic fill_conts();
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r = {$random(seed), $random(seed)};
            cont6[i] = r[47:0];
            cont2[i] = r[63:48];
            cont4[i] = $random(seed);
        end
    endtask

    // other opcodes and the metadata are random, tenant ID goes on top
    task automatic build_phv(input tenant_t ten, input logic [19:0] op, output phv_t p);
        for (int i = 0; i < 8; i++) begin
            p[C6_LSB + 48 * i +: 48] = cont6[i];
            p[C4_LSB + 32 * i +: 32] = cont4[i];
            p[C2_LSB + 16 * i +: 16] = cont2[i];
        end
        for (int j = 0; j < 5; j++) begin
            p[OP0_TOP - 20 * j -: 20] = (j == STAGE) ? op : 20'($random(seed));
        end
        for (int m = 0; m < 8; m++) begin
            p[32 * m +: 32] = $random(seed);
        end
        p[TEN_LSB +: 4] = ten;
    endtask

    function automatic logic [7:0] operand(phv_t p, logic imm, logic [7:0] f);
        int lsb;
        if (imm) begin
            return f;
        end
        case (f[4:3])
            2'b10:   lsb = C6_LSB + 48 * int'(f[2:0]);
            2'b01:   lsb = C4_LSB + 32 * int'(f[2:0]);
            default: lsb = C2_LSB + 16 * int'(f[2:0]);
        endcase
        return p[lsb +: 8];
    endfunction

    function automatic logic expected_pred(phv_t p);
        logic [19:0] op;
        logic [7:0]  a;
        logic [7:0]  b;
        op = p[OP0_TOP - 20 * STAGE -: 20];
        a  = operand(p, op[17], op[16:9]);
        b  = operand(p, op[8], op[7:0]);
        case (op[19:18])
            2'b00:   return a > b;
            2'b01:   return a >= b;
            2'b10:   return a == b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic key_t expected_key(phv_t p);
        key_off_t off;
        key_t     k;
        off = off_model[p[TEN_LSB +: 4]];
        k = '0;
        k[100:53]    = p[C6_LSB + 48 * int'(off.idx_6b) +: 48];
        k[52:21]     = p[C4_LSB + 32 * int'(off.idx_4b) +: 32];
        k[20:5]      = p[C2_LSB + 16 * int'(off.idx_2b) +: 16];
        k[4 - STAGE] = expected_pred(p);
        return k;
    endfunction

    // i below zero means an idle cycle is expected
    task automatic check_output(input int i);
        logic    v;
        key_t    ek;
        tenant_t ten;
        v = 1'b0;
        if (i >= 0) begin
            v = vld_seq[i];
        end
        if (phv_valid_out !== v) value_mismatch("phv_valid_out", phv_t'(phv_valid_out), phv_t'(v));
        if (key_valid_out !== v) value_mismatch("key_valid_out", phv_t'(key_valid_out), phv_t'(v));
        if (!v) begin
            if (key_out !== '0) value_mismatch("key_out", phv_t'(key_out), '0);
        end else begin
            ek = expected_key(phv_seq[i]);
            if (phv_out !== phv_seq[i]) value_mismatch("phv_out", phv_out, phv_seq[i]);
            if (key_out !== ek) value_mismatch("key_out", phv_t'(key_out), phv_t'(ek));
            if (pred_chk && key_out[4 - STAGE] !== pred_seq[i]) begin
                value_mismatch("key_out predicate bit", phv_t'(key_out[4 - STAGE]),
                               phv_t'(pred_seq[i]));
            end
        end
        // mask follows the tenant of every input cycle, valid or not
        if (i >= 0) begin
            ten = phv_seq[i][TEN_LSB +: 4];
            if (key_mask_out !== mask_model[ten]) begin
                value_mismatch("key_mask_out", phv_t'(key_mask_out), phv_t'(mask_model[ten]));
            end
        end
    endtask

    // outputs of input cycle t are checked three edges later
    task automatic run_stream(input int n);
        for (int t = 0; t < n + 3; t++) begin
            @(posedge clk);
            if (t < n) begin
                phv_in       <= phv_seq[t];
                phv_valid_in <= vld_seq[t];
            end else begin
                phv_valid_in <= 1'b0;
            end
            @(negedge clk);
            check_output(t - 3);
        end
    endtask

    `include "key_extract_tests.svh"

    initial begin
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        cfg_req      = 1'b0;
        cfg_sel      = SEL_OFFSET;
        cfg_index    = '0;
        cfg_data     = '0;
        pred_chk     = 1'b0;
        for (int t = 0; t < 16; t++) begin
            off_model[t]  = '0;
            mask_model[t] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_cfg_handshake();
        test_tenant_isolation();
        test_predicate();
        test_streaming();
        $display("tests run %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== logic/key_extract_top.sv ====
/*
 * Key extractor of one match-action stage, STAGE_ID in 0..4.
 * PHV, key and mask come out three cycles after phv_valid_in, no stall.
 * Offset writes use the low 9 bits of cfg_data. A PHV entering after
 * cfg_ack rises sees the new table entry.
 */
`timescale 1ns/1ps

module key_extract_top #(
    parameter int STAGE_ID = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     phv_in,
    input  logic                      phv_valid_in,
    input  logic                      cfg_req,
    input  key_extract_pkg::cfg_sel_e cfg_sel,
    input  key_extract_pkg::tenant_t  cfg_index,
    input  key_extract_pkg::key_t     cfg_data,
    output logic                      cfg_ack,
    output key_extract_pkg::phv_t     phv_out,
    output logic                      phv_valid_out,
    output key_extract_pkg::key_t     key_out,
    output logic                      key_valid_out,
    output key_extract_pkg::key_t     key_mask_out
);
    import key_extract_pkg::*;

    tenant_t  rd_tenant;
    key_off_t offset_s1;
    key_t     mask_s1;
    phv_t     phv_s1;
    logic     pred_s2;

    tbl_wr_if    u_wr_if ();
    key_stage_if u_st_if ();

    // tenant ID sits in the metadata
    assign rd_tenant = phv_in[TENANT_LSB +: TBL_AW];

    key_cfg_ctrl u_cfg_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_req   (cfg_req),
        .cfg_sel   (cfg_sel),
        .cfg_index (cfg_index),
        .cfg_data  (cfg_data),
        .cfg_ack   (cfg_ack),
        .wr        (u_wr_if)
    );

    tenant_table #(.entry_t(key_off_t)) u_off_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (u_wr_if.wr_en_off),
        .wr_index (u_wr_if.wr_index),
        .wr_data  (key_off_t'(u_wr_if.wr_data[$bits(key_off_t)-1:0])),
        .rd_index (rd_tenant),
        .rd_data  (offset_s1)
    );

    tenant_table #(.entry_t(key_t)) u_mask_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (u_wr_if.wr_en_mask),
        .wr_index (u_wr_if.wr_index),
        .wr_data  (u_wr_if.wr_data),
        .rd_index (rd_tenant),
        .rd_data  (mask_s1)
    );

    field_select u_field_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid_in (phv_valid_in),
        .offset       (offset_s1),
        .phv_s1       (phv_s1),
        .st           (u_st_if)
    );

    predicate_unit #(.STAGE_ID(STAGE_ID)) u_predicate (
        .clk    (clk),
        .rst_n  (rst_n),
        .phv_s1 (phv_s1),
        .pred   (pred_s2)
    );

    key_assemble #(.STAGE_ID(STAGE_ID)) u_key_assemble (
        .clk           (clk),
        .rst_n         (rst_n),
        .st            (u_st_if),
        .pred          (pred_s2),
        .mask_s1       (mask_s1),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

// ==== logic/key_assemble.sv ====
/*
 * Output stage. Builds the key from the stage 2 fields and the predicate,
 * and lines the PHV and mask up with it. Key reads zero on idle cycles,
 * the mask is passed on every cycle.
 */
`timescale 1ns/1ps

module key_assemble #(
    parameter int STAGE_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    key_stage_if.dst              st,
    input  logic                  pred,
    input  key_extract_pkg::key_t mask_s1,
    output key_extract_pkg::phv_t phv_out,
    output logic                  phv_valid_out,
    output key_extract_pkg::key_t key_out,
    output logic                  key_valid_out,
    output key_extract_pkg::key_t key_mask_out
);
    import key_extract_pkg::*;

    // stage 0 owns the top predicate bit
    localparam int PRED_BIT = N_OP - 1 - STAGE_ID;

    key_t key_next;
    key_t mask_s2;

    always_comb begin
        key_next = '0;
        key_next[KEY_6B_LSB +: W_6B] = st.f6;
        key_next[KEY_4B_LSB +: W_4B] = st.f4;
        key_next[KEY_2B_LSB +: W_2B] = st.f2;
        key_next[PRED_BIT]           = pred;
    end

    always_ff @(posedge clk) begin
        mask_s2      <= mask_s1;
        key_mask_out <= mask_s2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out       <= '0;
            phv_valid_out <= 1'b0;
            key_out       <= '0;
            key_valid_out <= 1'b0;
        end else begin
            phv_out       <= st.phv;
            phv_valid_out <= st.valid;
            key_out       <= st.valid ? key_next : '0;
            key_valid_out <= st.valid;
        end
    end

    a_out_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (key_valid_out == phv_valid_out) && (key_valid_out || key_out == '0));

endmodule

// ==== logic/predicate_unit.sv ====
/*
 * Predicate bit of this stage, from opcode STAGE_ID of the stage 1 PHV.
 * Operands are 8-bit, unsigned. Container type 11 reads as 2-byte.
 * Result is registered, so it lines up with the stage 2 fields.
 */
`timescale 1ns/1ps

module predicate_unit #(
    parameter int STAGE_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  key_extract_pkg::phv_t phv_s1,
    output logic                  pred
);
    import key_extract_pkg::*;

    localparam int OP_MSB = OP0_MSB - OP_W * STAGE_ID;

    logic [OP_W-1:0] op;
    logic [7:0]      opnd_a;
    logic [7:0]      opnd_b;
    logic            result;

    function automatic logic [7:0] cont_byte(phv_t phv, logic [1:0] ctype,
                                             logic [CIDX_W-1:0] idx);
        logic [W_6B-1:0] c6;
        logic [W_4B-1:0] c4;
        logic [W_2B-1:0] c2;
        c6 = cont_6b(phv, idx);
        c4 = cont_4b(phv, idx);
        c2 = cont_2b(phv, idx);
        case (ctype)
            CT_6B:   return c6[7:0];
            CT_4B:   return c4[7:0];
            default: return c2[7:0];
        endcase
    endfunction

    assign op = phv_s1[OP_MSB -: OP_W];

    // immediate wins over the container fields, which overlap it
    assign opnd_a = op[OP_IMM_FLAG_A] ? op[OP_IMM_LSB_A +: 8]
                  : cont_byte(phv_s1, op[OP_TYPE_LSB_A +: 2], op[OP_IDX_LSB_A +: CIDX_W]);
    assign opnd_b = op[OP_IMM_FLAG_B] ? op[OP_IMM_LSB_B +: 8]
                  : cont_byte(phv_s1, op[OP_TYPE_LSB_B +: 2], op[OP_IDX_LSB_B +: CIDX_W]);

    always_comb begin
        case (op[OP_CMP_LSB +: 2])
            CMP_GT:  result = opnd_a > opnd_b;
            CMP_GE:  result = opnd_a >= opnd_b;
            CMP_EQ:  result = opnd_a == opnd_b;
            default: result = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred <= 1'b0;
        end else begin
            pred <= result;
        end
    end

    a_stage_range: assert property (@(posedge clk) STAGE_ID >= 0 && STAGE_ID < N_OP);

endmodule

// ==== logic/field_select.sv ====
/*
 * PHV stages 1 and 2. The offset entry arrives with the stage 1 PHV and
 * names one container of each width, which are sliced out at stage 2.
 * No stall, one PHV accepted per cycle.
 */
`timescale 1ns/1ps

module field_select (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     phv_in,
    input  logic                      phv_valid_in,
    input  key_extract_pkg::key_off_t offset,
    output key_extract_pkg::phv_t     phv_s1,
    key_stage_if.src                  st
);
    import key_extract_pkg::*;

    logic valid_s1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_s1   <= '0;
            valid_s1 <= 1'b0;
            st.phv   <= '0;
            st.valid <= 1'b0;
        end else begin
            phv_s1   <= phv_in;
            valid_s1 <= phv_valid_in;
            st.phv   <= phv_s1;
            st.valid <= valid_s1;
        end
    end

    // fields follow the stage 1 PHV whether valid or not
    always_ff @(posedge clk) begin
        st.f6 <= cont_6b(phv_s1, offset.idx_6b);
        st.f4 <= cont_4b(phv_s1, offset.idx_4b);
        st.f2 <= cont_2b(phv_s1, offset.idx_2b);
    end

endmodule

// ==== logic/tenant_table.sv ====
/*
 * Per-tenant register table, one entry per tenant ID.
 * Read data appears one cycle after the read index. A write and a read of
 * the same entry on one edge return the old entry.
 */
`timescale 1ns/1ps

module tenant_table #(
    parameter type entry_t = logic
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  key_extract_pkg::tenant_t wr_index,
    input  entry_t                   wr_data,
    input  key_extract_pkg::tenant_t rd_index,
    output entry_t                   rd_data
);
    import key_extract_pkg::*;

    entry_t entries [TBL_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TBL_DEPTH; i++) begin
                entries[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                entries[wr_index] <= wr_data;
            end
            rd_data <= entries[rd_index];
        end
    end

    a_rd_index_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_index));

endmodule

// ==== logic/key_cfg_ctrl.sv ====
/*
 * Four-phase req/ack configuration port for the offset and mask tables.
 * Host keeps sel, index and data stable while req is high and starts a
 * new request only after ack has dropped. One table write per request.
 */
`timescale 1ns/1ps

module key_cfg_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_req,
    input  key_extract_pkg::cfg_sel_e cfg_sel,
    input  key_extract_pkg::tenant_t  cfg_index,
    input  key_extract_pkg::key_t     cfg_data,
    output logic                      cfg_ack,
    tbl_wr_if.ctrl                    wr
);
    import key_extract_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_ACK} state_e;

    state_e state;
    logic   start;

    assign start = (state == ST_IDLE) && cfg_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            cfg_ack       <= 1'b0;
            wr.wr_en_off  <= 1'b0;
            wr.wr_en_mask <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cfg_req) begin
                        wr.wr_en_off  <= (cfg_sel == SEL_OFFSET);
                        wr.wr_en_mask <= (cfg_sel == SEL_MASK);
                        state         <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    // table takes the entry on this edge
                    wr.wr_en_off  <= 1'b0;
                    wr.wr_en_mask <= 1'b0;
                    cfg_ack       <= 1'b1;
                    state         <= ST_ACK;
                end
                ST_ACK: begin
                    if (!cfg_req) begin
                        cfg_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // captured once on request entry
    always_ff @(posedge clk) begin
        if (start) begin
            wr.wr_index <= cfg_index;
            wr.wr_data  <= cfg_data;
        end
    end

    a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr.wr_en_off && wr.wr_en_mask));

    // ack must stay up until the host lets go of req
    a_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ack && cfg_req |=> cfg_ack);

endmodule

// ==== logic/key_ifs.sv ====
/*
 * Table write bundle and the stage 2 bundle of the extractor.
 * Neither interface carries a clock, both sides share the design clock.
 */
`timescale 1ns/1ps

// one table write, at most one enable high
interface tbl_wr_if;
    import key_extract_pkg::*;

    logic    wr_en_off;
    logic    wr_en_mask;
    tenant_t wr_index;
    key_t    wr_data;

    modport ctrl (output wr_en_off, output wr_en_mask, output wr_index, output wr_data);
    modport tbl  (input wr_en_off, input wr_en_mask, input wr_index, input wr_data);
endinterface

// everything below is aligned at stage 2
interface key_stage_if;
    import key_extract_pkg::*;

    phv_t            phv;
    logic            valid;
    logic [W_6B-1:0] f6;
    logic [W_4B-1:0] f4;
    logic [W_2B-1:0] f2;

    modport src (output phv, output valid, output f6, output f4, output f2);
    modport dst (input phv, input valid, input f6, input f4, input f2);
endinterface

// ==== logic/key_extract_pkg.sv ====
/*
 * Layout of the PHV and of the lookup key for one key extractor stage.
 * Container index 7 sits at the most significant end of each region.
 * Operands of the comparison opcode are the low byte of a container.
 */
package key_extract_pkg;

    localparam int W_2B    = 16;
    localparam int W_4B    = 32;
    localparam int W_6B    = 48;
    localparam int N_CONT  = 8;
    localparam int CIDX_W  = $clog2(N_CONT);
    localparam int OP_W    = 20;
    localparam int N_OP    = 5;
    localparam int META_W  = 256;
    localparam int PHV_LEN = N_CONT * (W_6B + W_4B + W_2B) + N_OP * OP_W + META_W;

    // lsb of container 0 in each region
    localparam int CONT2_LSB = META_W + N_OP * OP_W;
    localparam int CONT4_LSB = CONT2_LSB + N_CONT * W_2B;
    localparam int CONT6_LSB = CONT4_LSB + N_CONT * W_4B;
    // opcode i ends at OP0_MSB - OP_W*i
    localparam int OP0_MSB   = CONT2_LSB - 1;

    // key is {f6, f4, f2, one predicate bit per stage}
    localparam int KEY_LEN    = W_6B + W_4B + W_2B + N_OP;
    localparam int KEY_2B_LSB = N_OP;
    localparam int KEY_4B_LSB = KEY_2B_LSB + W_2B;
    localparam int KEY_6B_LSB = KEY_4B_LSB + W_4B;

    localparam int TENANT_LSB = 133;
    localparam int TBL_DEPTH  = 16;
    localparam int TBL_AW     = $clog2(TBL_DEPTH);

    // opcode fields, operand A then operand B
    localparam int OP_CMP_LSB    = 18;
    localparam int OP_IMM_FLAG_A = 17;
    localparam int OP_IMM_LSB_A  = 9;
    localparam int OP_TYPE_LSB_A = 12;
    localparam int OP_IDX_LSB_A  = 9;
    localparam int OP_IMM_FLAG_B = 8;
    localparam int OP_IMM_LSB_B  = 0;
    localparam int OP_TYPE_LSB_B = 3;
    localparam int OP_IDX_LSB_B  = 0;

    localparam logic [1:0] CMP_GT = 2'b00;
    localparam logic [1:0] CMP_GE = 2'b01;
    localparam logic [1:0] CMP_EQ = 2'b10;
    localparam logic [1:0] CT_6B  = 2'b10;
    localparam logic [1:0] CT_4B  = 2'b01;

    typedef logic [PHV_LEN-1:0] phv_t;
    typedef logic [KEY_LEN-1:0] key_t;
    typedef logic [TBL_AW-1:0]  tenant_t;

    typedef struct packed {
        logic [CIDX_W-1:0] idx_6b;
        logic [CIDX_W-1:0] idx_4b;
        logic [CIDX_W-1:0] idx_2b;
    } key_off_t;

    typedef enum logic {SEL_OFFSET, SEL_MASK} cfg_sel_e;

    function automatic logic [W_6B-1:0] cont_6b(phv_t phv, logic [CIDX_W-1:0] idx);
        return phv[CONT6_LSB + W_6B * int'(idx) +: W_6B];
    endfunction

    function automatic logic [W_4B-1:0] cont_4b(phv_t phv, logic [CIDX_W-1:0] idx);
        return phv[CONT4_LSB + W_4B * int'(idx) +: W_4B];
    endfunction

    function automatic logic [W_2B-1:0] cont_2b(phv_t phv, logic [CIDX_W-1:0] idx);
        return phv[CONT2_LSB + W_2B * int'(idx) +: W_2B];
    endfunction

endpackage
